// ==== bench/tcdm_patterns.mem ====
// master op(1 load, 0 store) byte-address wdata byte-enable expected-rdata
// one access per line, master ff ends the list
// SRAM stores from each master, one per bank
0 0 00000100 11223344 f 00000000
1 0 00000204 55667788 f 00000000
2 0 00003ff8 deadbeef f 00000000
3 0 0000155c 0badf00d f 00000000
// SRAM loads from other masters, upper address bits ignored
3 1 00000100 00000000 f 11223344
2 1 00000204 00000000 f 55667788
1 1 00003ff8 00000000 f deadbeef
0 1 0000155c 00000000 f 0badf00d
1 1 10000100 00000000 f 11223344
// SCM region, bit 14 set
0 0 00004004 cafebabe f 00000000
1 0 00004ff8 01234567 f 00000000
2 0 000045ac 89abcdef f 00000000
3 0 00004800 feedface f 00000000
1 1 00004004 00000000 f cafebabe
2 1 00004ff8 00000000 f 01234567
3 1 000045ac 00000000 f 89abcdef
0 1 00004800 00000000 f feedface
// partial stores, merged read-back
2 0 00003ff8 aabbccdd 5 00000000
0 1 00003ff8 00000000 f debbbedd
1 0 00004004 00000000 8 00000000
3 1 00004004 00000000 f 00febabe
3 0 00000100 ffffffff 6 00000000
1 1 00000100 00000000 f 11ffff44
ff 0 00000000 00000000 0 00000000

// ==== filelist.f ====
+incdir+hdl
hdl/tcdm_addr_pkg.sv
hdl/tcdm_bus_pkg.sv
hdl/tcdm_bank_if.sv
hdl/tcdm_arbiter.sv
hdl/tcdm_req_router.sv
hdl/tcdm_bank_pipe.sv
hdl/tcdm_resp_router.sv
hdl/tcdm_xbar_top.sv
bench/tcdm_assert.sv
bench/tcdm_tb.sv

// ==== Makefile ====
TOP = tcdm_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then \
		echo "simulation FAILED"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)
	verilator --lint-only -Wall -f filelist.f --top-module tcdm_xbar_top

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tcdm_tb.sv ====
// testbench for the TCDM crossbar
// memories are behavioral, answer 1 cycle after req, honour byte enables
// patterns come from bench/tcdm_patterns.mem, run from the project root
// a scoreboard predicts every response from the grant and a shadow memory
`include "tcdm_cfg.svh"
`default_nettype none

module tcdm_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NM      = `TCDM_N_MASTER;
  localparam int NB      = `TCDM_N_BANK;
  localparam int PAT_MAX = 32;
  localparam int N_CONF  = 8;
  localparam int N_PIPE  = 8;
  localparam int N_RAND  = 60;

  logic clk;
  logic arst_n;
  logic [NM-1:0]                   req, wen, gnt, r_valid;
  logic [NM-1:0][`TCDM_ADDR_W-1:0] add;
  logic [NM-1:0][`TCDM_DATA_W-1:0] wdata, r_rdata;
  logic [NM-1:0][`TCDM_BE_W-1:0]   be;
  logic [NB-1:0]                   sram_req, sram_wen, scm_req, scm_wen;
  logic [NB-1:0][`TCDM_SRAM_AW-1:0] sram_add;
  logic [NB-1:0][`TCDM_SCM_AW-1:0]  scm_add;
  logic [NB-1:0][`TCDM_DATA_W-1:0] sram_wdata, scm_wdata, sram_rdata, scm_rdata;
  logic [NB-1:0][`TCDM_BE_W-1:0]   sram_be, scm_be;

  logic [31:0] sram_mem [NB][2**`TCDM_SRAM_AW];
  logic [31:0] scm_mem  [NB][2**`TCDM_SCM_AW];
  // six words per line, see the pattern file
  logic [31:0] pat [6*PAT_MAX];

  // shadow keyed by bank * 4096 + region * 2048 + word
  logic [31:0] shadow [int];
  int          exp_cyc_q [NM][$];
  logic [31:0] exp_dat_q [NM][$];
  bit          exp_rd_q  [NM][$];
  int          cyc = 0;
  int          cyc_limit = 100000;

  tcdm_xbar_top dut_i (
    .clk (clk), .arst_n_i (arst_n),
    .data_req_i (req), .data_add_i (add), .data_wen_i (wen),
    .data_wdata_i (wdata), .data_be_i (be),
    .data_gnt_o (gnt), .data_r_valid_o (r_valid), .data_r_rdata_o (r_rdata),
    .data_req_sram_o (sram_req), .data_add_sram_o (sram_add), .data_wen_sram_o (sram_wen),
    .data_wdata_sram_o (sram_wdata), .data_be_sram_o (sram_be),
    .data_r_rdata_sram_i (sram_rdata),
    .data_req_scm_o (scm_req), .data_add_scm_o (scm_add), .data_wen_scm_o (scm_wen),
    .data_wdata_scm_o (scm_wdata), .data_be_scm_o (scm_be),
    .data_r_rdata_scm_i (scm_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  task automatic stop_run(string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act)
    begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      stop_run("value mismatch");
    end
  endtask

  // power-up content, spread over the whole key
  function automatic logic [31:0] fill_word(int key);
    return 32'h5a3c_0000 ^ (32'(key) * 32'h0001_9e37);
  endfunction

  // byte address to memory key, bit 14 is the region
  function automatic int mem_key(logic [31:0] a);
    if (a[14])
      return int'(a[3:2]) * 4096 + 2048 + int'(a[11:4]);
    return int'(a[3:2]) * 4096 + int'(a[13:4]);
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] mask);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++)
      if (mask[i])
        res[8*i +: 8] = new_w[8*i +: 8];
    return res;
  endfunction

  // memory models, loads read, stores merge bytes
  always @(posedge clk)
  begin
    for (int b = 0; b < NB; b++)
    begin
      if (sram_req[b])
      begin
        if (sram_wen[b])
          sram_rdata[b] <= sram_mem[b][sram_add[b]];
        else
          for (int i = 0; i < 4; i++)
            if (sram_be[b][i])
              sram_mem[b][sram_add[b]][8*i +: 8] <= sram_wdata[b][8*i +: 8];
      end
      if (scm_req[b])
      begin
        if (scm_wen[b])
          scm_rdata[b] <= scm_mem[b][scm_add[b]];
        else
          for (int i = 0; i < 4; i++)
            if (scm_be[b][i])
              scm_mem[b][scm_add[b]][8*i +: 8] <= scm_wdata[b][8*i +: 8];
      end
    end
  end

  // cycle count and timeout
  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc > cyc_limit)
      stop_run("timeout, the run did not finish within its cycle limit");
  end

  //////////////////////////////////////////////////
  // scoreboard, sampled mid-cycle
  //////////////////////////////////////////////////
  always @(negedge clk)
  begin
    int          key;
    int          e_cyc;
    logic [31:0] e_dat;
    bit          e_rd;
    logic [31:0] cur;
    // bound protocol checks, counted at the edge before
    if (dut_i.assert_i.fail_port + dut_i.assert_i.fail_resp
        + dut_i.assert_i.fail_dup != 0)
      stop_run("a protocol assertion failed");
    if (arst_n)
    begin
      for (int m = 0; m < NM; m++)
      begin
        if (r_valid[m])
        begin
          if (exp_cyc_q[m].size() == 0)
            stop_run("response arrived without a matching grant");
          e_cyc = exp_cyc_q[m].pop_front();
          e_dat = exp_dat_q[m].pop_front();
          e_rd  = exp_rd_q[m].pop_front();
          check_value($sformatf("response cycle m%0d", m), e_cyc, cyc);
          if (e_rd)
            check_value($sformatf("response data m%0d", m), e_dat, r_rdata[m]);
        end
        // grant edge is the next one, response two edges later
        if (gnt[m])
        begin
          key = mem_key(add[m]);
          cur = shadow.exists(key) ? shadow[key] : fill_word(key);
          exp_cyc_q[m].push_back(cyc + 2);
          exp_dat_q[m].push_back(cur);
          exp_rd_q[m].push_back(wen[m]);
          if (!wen[m])
            shadow[key] = merge_bytes(cur, wdata[m], be[m]);
        end
      end
    end
  end

  // one access from one master, waits for grant and response
  task automatic run_access(input int m, input logic ld, input logic [31:0] a,
                            input logic [31:0] wd, input logic [3:0] mask,
                            input bit chk_ports, output logic [31:0] rd);
    int            waited;
    logic [NB-1:0] hot;
    waited = 0;
    hot    = '0;
    @(posedge clk);
    #1;
    req[m]   = 1'b1;
    wen[m]   = ld;
    add[m]   = a;
    wdata[m] = wd;
    be[m]    = mask;
    @(negedge clk);
    while (!gnt[m])
    begin
      waited++;
      if (waited > 8)
        stop_run("a lone master was never granted");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req[m] = 1'b0;
    @(negedge clk);
    // memory request cycle, only the decoded port of the decoded bank
    if (chk_ports)
    begin
      hot[a[3:2]] = 1'b1;
      check_value("sram req", a[14] ? '0 : 32'(hot), 32'(sram_req));
      check_value("scm req", a[14] ? 32'(hot) : '0, 32'(scm_req));
      if (a[14])
        check_value("scm addr", 32'(a[11:4]), 32'(scm_add[a[3:2]]));
      else
        check_value("sram addr", 32'(a[13:4]), 32'(sram_add[a[3:2]]));
    end
    @(negedge clk);
    check_value("r_valid", 32'd1, 32'(r_valid[m]));
    rd = r_rdata[m];
  endtask

  task automatic check_idle(string name);
    check_value({name, " gnt"}, '0, 32'(gnt));
    check_value({name, " r_valid"}, '0, 32'(r_valid));
    check_value({name, " sram req"}, '0, 32'(sram_req));
    check_value({name, " scm req"}, '0, 32'(scm_req));
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial
  begin
    int            n_pat;
    int            m;
    int            waited;
    int            bank;
    logic [10:0]   word;
    logic [31:0]   ra;
    logic [31:0]   rd;
    logic [NM-1:0] g;
    void'($urandom(32'h1b10_e381));
    req = '0;
    wen = '0;
    add = '0;
    wdata = '0;
    be = '0;
    sram_rdata = '0;
    scm_rdata = '0;
    for (int b = 0; b < NB; b++)
    begin
      for (int a = 0; a < 2**`TCDM_SRAM_AW; a++)
        sram_mem[b][a] = fill_word(b * 4096 + a);
      for (int a = 0; a < 2**`TCDM_SCM_AW; a++)
        scm_mem[b][a] = fill_word(b * 4096 + 2048 + a);
    end
    for (int i = 0; i < 6 * PAT_MAX; i++)
      pat[i] = 32'hff;
    $readmemh("bench/tcdm_patterns.mem", pat);
    n_pat = 0;
    while (n_pat < PAT_MAX && pat[6*n_pat] != 32'hff)
      n_pat++;
    cyc_limit = (n_pat + N_CONF + N_PIPE + N_RAND) * 10 + 100;

    // reset, outputs quiet throughout
    arst_n = 1'b0;
    repeat (8)
    begin
      @(negedge clk);
      check_idle("reset");
    end
    @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_idle("after reset");

    // pattern replay, SRAM, SCM and byte enables
    for (int i = 0; i < n_pat; i++)
    begin
      run_access(int'(pat[6*i]), pat[6*i+1][0], pat[6*i+2], pat[6*i+3],
                 pat[6*i+4][3:0], 1'b1, rd);
      if (pat[6*i+1][0])
        check_value($sformatf("pattern %0d", i), pat[6*i+5], rd);
    end

    // conflicts, all masters on bank 2, stores then loads
    for (int round = 0; round < 2; round++)
    begin
      @(posedge clk);
      #1;
      for (int k = 0; k < NM; k++)
      begin
        req[k]   = 1'b1;
        wen[k]   = 1'(round);
        add[k]   = 32'(((32'h60 + k) << 4) | 8);
        wdata[k] = 32'hc0f1_0000 + 32'(k);
        be[k]    = 4'hf;
      end
      waited = 0;
      while (req != '0)
      begin
        @(negedge clk);
        g = gnt;
        check_value("conflict grant count", 1, $countones(g));
        check_value("conflict grant pending", '0, 32'(g & ~req));
        waited++;
        if (waited > NM)
          stop_run("a conflicting master waited more than 4 cycles");
        @(posedge clk);
        #1;
        req = req & ~g;
      end
      repeat (3) @(posedge clk);
    end

    // back-to-back from master 1 over rotating banks
    for (int k = 0; k < N_PIPE; k++)
    begin
      @(posedge clk);
      #1;
      req[1]   = 1'b1;
      wen[1]   = k[0];
      add[1]   = 32'(((32'h70 + k) << 4) | ((k % 4) << 2));
      wdata[1] = 32'h9000_0000 + 32'(k);
      be[1]    = 4'hf;
      @(negedge clk);
      check_value("pipeline grant", 1, 32'(gnt[1]));
    end
    @(posedge clk);
    #1;
    req[1] = 1'b0;
    repeat (3) @(posedge clk);

    // random mixed traffic, small word range so loads hit earlier stores
    for (int k = 0; k < N_RAND; k++)
    begin
      m    = $urandom_range(NM - 1);
      bank = $urandom_range(NB - 1);
      repeat ($urandom_range(3)) @(posedge clk);
      if ($urandom_range(1) == 1)
        word = 11'h400 | 11'($urandom_range(15));
      else
        word = 11'($urandom_range(15));
      ra = {17'h0, word, 2'(bank), 2'b00};
      ra[31:15] = 17'($urandom);
      run_access(m, 1'($urandom_range(1)), ra, $urandom, 4'($urandom), 1'b0, rd);
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    for (int k = 0; k < NM; k++)
      check_value($sformatf("responses left m%0d", k), 0, exp_cyc_q[k].size());
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/tcdm_assert.sv ====
// protocol checks on the crossbar top level, attached by bind
// response check assumes the fixed 2 cycle latency of the top level
`include "tcdm_cfg.svh"
`default_nettype none

module tcdm_assert
  import tcdm_bus_pkg::*;
(
  input logic                           clk,
  input logic                           arst_n_i,
  input logic [`TCDM_N_MASTER-1:0]      gnt_i,
  input logic [`TCDM_N_MASTER-1:0]      r_valid_i,
  input logic [`TCDM_N_BANK-1:0]        sram_req_i,
  input logic [`TCDM_N_BANK-1:0]        scm_req_i,
  input logic [`TCDM_N_BANK-1:0]        gnt_valid_i,
  input master_idx_t [`TCDM_N_BANK-1:0] gnt_idx_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // failure counts, one per property
  int unsigned fail_port = 0;
  int unsigned fail_resp = 0;
  int unsigned fail_dup  = 0;

  // two banks granting the same master
  logic dup_gnt;

  always_comb
  begin
    dup_gnt = 1'b0;
    for (int b1 = 0; b1 < `TCDM_N_BANK; b1++)
    begin
      for (int b2 = b1 + 1; b2 < `TCDM_N_BANK; b2++)
      begin
        if (gnt_valid_i[b1] && gnt_valid_i[b2] && (gnt_idx_i[b1] == gnt_idx_i[b2]))
          dup_gnt = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////
  // one memory port per bank at a time
  a_one_port: assert property (@(posedge clk) disable iff (!arst_n_i)
    (sram_req_i & scm_req_i) == '0)
    else
    begin
      $error("SRAM and SCM req high on the same bank");
      fail_port++;
    end

  // grant two edges back means response now
  a_resp_lat: assert property (@(posedge clk) disable iff (!arst_n_i)
    ($past(gnt_i, 2) & ~r_valid_i) == '0)
    else
    begin
      $error("grant not followed by r_valid 2 cycles later");
      fail_resp++;
    end

  a_no_dup: assert property (@(posedge clk) disable iff (!arst_n_i) !dup_gnt)
    else
    begin
      $error("master granted by two banks at once");
      fail_dup++;
    end

endmodule

bind tcdm_xbar_top tcdm_assert assert_i (
  .clk         (clk),
  .arst_n_i    (arst_n_i),
  .gnt_i       (data_gnt_o),
  .r_valid_i   (data_r_valid_o),
  .sram_req_i  (data_req_sram_o),
  .scm_req_i   (data_req_scm_o),
  .gnt_valid_i (gnt_valid),
  .gnt_idx_i   (gnt_idx)
);

`default_nettype wire

// ==== hdl/tcdm_xbar_top.sv ====
// TCDM crossbar, 4 masters on 4 word-interleaved banks
// each bank has an SRAM and an SCM port, picked by address bit 14
// memory req comes 1 cycle after the grant edge, r_valid 2 cycles after
// memories must answer 1 cycle after req and never stall
// data_wen 1 is a load, 0 a store, as on the memory ports
`include "tcdm_cfg.svh"
`default_nettype none

module tcdm_xbar_top
  import tcdm_bus_pkg::*;
(
  input  logic                                        clk,
  input  logic                                        arst_n_i,
  // master side
  input  logic [`TCDM_N_MASTER-1:0]                   data_req_i,
  input  logic [`TCDM_N_MASTER-1:0][`TCDM_ADDR_W-1:0] data_add_i,
  input  logic [`TCDM_N_MASTER-1:0]                   data_wen_i,
  input  logic [`TCDM_N_MASTER-1:0][`TCDM_DATA_W-1:0] data_wdata_i,
  input  logic [`TCDM_N_MASTER-1:0][`TCDM_BE_W-1:0]   data_be_i,
  output logic [`TCDM_N_MASTER-1:0]                   data_gnt_o,
  output logic [`TCDM_N_MASTER-1:0]                   data_r_valid_o,
  output logic [`TCDM_N_MASTER-1:0][`TCDM_DATA_W-1:0] data_r_rdata_o,
  // SRAM ports
  output logic [`TCDM_N_BANK-1:0]                     data_req_sram_o,
  output logic [`TCDM_N_BANK-1:0][`TCDM_SRAM_AW-1:0]  data_add_sram_o,
  output logic [`TCDM_N_BANK-1:0]                     data_wen_sram_o,
  output logic [`TCDM_N_BANK-1:0][`TCDM_DATA_W-1:0]   data_wdata_sram_o,
  output logic [`TCDM_N_BANK-1:0][`TCDM_BE_W-1:0]     data_be_sram_o,
  input  logic [`TCDM_N_BANK-1:0][`TCDM_DATA_W-1:0]   data_r_rdata_sram_i,
  // SCM ports
  output logic [`TCDM_N_BANK-1:0]                     data_req_scm_o,
  output logic [`TCDM_N_BANK-1:0][`TCDM_SCM_AW-1:0]   data_add_scm_o,
  output logic [`TCDM_N_BANK-1:0]                     data_wen_scm_o,
  output logic [`TCDM_N_BANK-1:0][`TCDM_DATA_W-1:0]   data_wdata_scm_o,
  output logic [`TCDM_N_BANK-1:0][`TCDM_BE_W-1:0]     data_be_scm_o,
  input  logic [`TCDM_N_BANK-1:0][`TCDM_DATA_W-1:0]   data_r_rdata_scm_i
);

  // arbiter <-> router
  logic [`TCDM_N_MASTER-1:0][`TCDM_N_BANK-1:0] bank_hit;
  logic [`TCDM_N_BANK-1:0]                     gnt_valid;
  master_idx_t [`TCDM_N_BANK-1:0]              gnt_idx;
  // request pipe -> response pipe
  logic [`TCDM_N_BANK-1:0]                     pipe_valid;
  master_idx_t [`TCDM_N_BANK-1:0]              pipe_id;
  logic [`TCDM_N_BANK-1:0]                     pipe_scm;

  tcdm_bank_req_if  bank_req ();
  tcdm_bank_resp_if bank_resp ();

  tcdm_arbiter arbiter_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .bank_hit_i  (bank_hit),
    .gnt_o       (data_gnt_o),
    .gnt_valid_o (gnt_valid),
    .gnt_idx_o   (gnt_idx)
  );

  tcdm_req_router req_router_i (
    .req_i       (data_req_i),
    .addr_i      (data_add_i),
    .wen_i       (data_wen_i),
    .wdata_i     (data_wdata_i),
    .be_i        (data_be_i),
    .bank_hit_o  (bank_hit),
    .gnt_valid_i (gnt_valid),
    .gnt_idx_i   (gnt_idx),
    .bank_req    (bank_req),
    .bank_resp   (bank_resp),
    .r_valid_o   (data_r_valid_o),
    .r_rdata_o   (data_r_rdata_o)
  );

  tcdm_bank_pipe bank_pipe_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .bank_req     (bank_req),
    .sram_req_o   (data_req_sram_o),
    .sram_addr_o  (data_add_sram_o),
    .sram_wen_o   (data_wen_sram_o),
    .sram_wdata_o (data_wdata_sram_o),
    .sram_be_o    (data_be_sram_o),
    .scm_req_o    (data_req_scm_o),
    .scm_addr_o   (data_add_scm_o),
    .scm_wen_o    (data_wen_scm_o),
    .scm_wdata_o  (data_wdata_scm_o),
    .scm_be_o     (data_be_scm_o),
    .pipe_valid_o (pipe_valid),
    .pipe_id_o    (pipe_id),
    .pipe_scm_o   (pipe_scm)
  );

  tcdm_resp_router resp_router_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .pipe_valid_i (pipe_valid),
    .pipe_id_i    (pipe_id),
    .pipe_scm_i   (pipe_scm),
    .sram_rdata_i (data_r_rdata_sram_i),
    .scm_rdata_i  (data_r_rdata_scm_i),
    .bank_resp    (bank_resp)
  );

endmodule

`default_nettype wire

// ==== hdl/tcdm_resp_router.sv ====
// response pipe stage per bank
// valid, id and region are flopped alongside the memory access,
// read data comes straight from the memories one cycle after their req
// stores get an rvalid too, their rdata is don't care
`include "tcdm_cfg.svh"
`default_nettype none

module tcdm_resp_router
  import tcdm_bus_pkg::*;
(
  input  logic                           clk,
  input  logic                           arst_n_i,
  input  logic [`TCDM_N_BANK-1:0]        pipe_valid_i,
  input  master_idx_t [`TCDM_N_BANK-1:0] pipe_id_i,
  input  logic [`TCDM_N_BANK-1:0]        pipe_scm_i,
  input  data_t [`TCDM_N_BANK-1:0]       sram_rdata_i,
  input  data_t [`TCDM_N_BANK-1:0]       scm_rdata_i,
  tcdm_bank_resp_if.resp                 bank_resp
);

  logic        [`TCDM_N_BANK-1:0] valid_q;
  master_idx_t [`TCDM_N_BANK-1:0] id_q;
  // 1 when the access went to SCM
  logic        [`TCDM_N_BANK-1:0] scm_q;

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      valid_q <= '0;
    else
      valid_q <= pipe_valid_i;
  end

  // steering info, only meaningful while valid
  always_ff @(posedge clk)
  begin
    for (int b = 0; b < `TCDM_N_BANK; b++)
    begin
      if (pipe_valid_i[b])
      begin
        id_q[b]  <= pipe_id_i[b];
        scm_q[b] <= pipe_scm_i[b];
      end
    end
  end

  //////////////////////////////////////////////////
  // pick the memory that served the access
  //////////////////////////////////////////////////
  for (genvar b = 0; b < `TCDM_N_BANK; b++)
  begin : g_rdata
    assign bank_resp.rdata[b] = scm_q[b] ? scm_rdata_i[b] : sram_rdata_i[b];
  end

  assign bank_resp.rvalid = valid_q;
  assign bank_resp.id     = id_q;

endmodule

`default_nettype wire

// ==== hdl/tcdm_bank_pipe.sv ====
// request pipe stage per bank, one cycle of latency
// the region bit routes the flopped request to SRAM or SCM
// wen, wdata and be go to both ports, only the req differs
// no back-pressure, a new request can be taken every cycle
`include "tcdm_cfg.svh"
`default_nettype none

module tcdm_bank_pipe
  import tcdm_addr_pkg::*, tcdm_bus_pkg::*;
(
  input  logic                                         clk,
  input  logic                                         arst_n_i,
  tcdm_bank_req_if.pipe                                bank_req,
  // SRAM side
  output logic [`TCDM_N_BANK-1:0]                      sram_req_o,
  output logic [`TCDM_N_BANK-1:0][`TCDM_SRAM_AW-1:0]   sram_addr_o,
  output logic [`TCDM_N_BANK-1:0]                      sram_wen_o,
  output data_t [`TCDM_N_BANK-1:0]                     sram_wdata_o,
  output be_t   [`TCDM_N_BANK-1:0]                     sram_be_o,
  // SCM side
  output logic [`TCDM_N_BANK-1:0]                      scm_req_o,
  output logic [`TCDM_N_BANK-1:0][`TCDM_SCM_AW-1:0]    scm_addr_o,
  output logic [`TCDM_N_BANK-1:0]                      scm_wen_o,
  output data_t [`TCDM_N_BANK-1:0]                     scm_wdata_o,
  output be_t   [`TCDM_N_BANK-1:0]                     scm_be_o,
  // towards the response stage
  output logic [`TCDM_N_BANK-1:0]                      pipe_valid_o,
  output master_idx_t [`TCDM_N_BANK-1:0]               pipe_id_o,
  output logic [`TCDM_N_BANK-1:0]                      pipe_scm_o
);

  logic        [`TCDM_N_BANK-1:0] req_q;
  mem_addr_u   [`TCDM_N_BANK-1:0] addr_q;
  logic        [`TCDM_N_BANK-1:0] wen_q;
  data_t       [`TCDM_N_BANK-1:0] wdata_q;
  be_t         [`TCDM_N_BANK-1:0] be_q;
  master_idx_t [`TCDM_N_BANK-1:0] id_q;

  // valid flag
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      req_q <= '0;
    else
      req_q <= bank_req.req;
  end

  // payload, loaded only on a request
  always_ff @(posedge clk)
  begin
    for (int b = 0; b < `TCDM_N_BANK; b++)
    begin
      if (bank_req.req[b])
      begin
        addr_q[b]  <= bank_req.addr[b];
        wen_q[b]   <= bank_req.wen[b];
        wdata_q[b] <= bank_req.wdata[b];
        be_q[b]    <= bank_req.be[b];
        id_q[b]    <= bank_req.id[b];
      end
    end
  end

  //////////////////////////////////////////////////
  // region split, address from the matching view
  //////////////////////////////////////////////////
  for (genvar b = 0; b < `TCDM_N_BANK; b++)
  begin : g_split
    assign sram_req_o[b]   = req_q[b] && !addr_q[b].sram.region;
    assign sram_addr_o[b]  = addr_q[b].sram.addr;
    assign scm_req_o[b]    = req_q[b] && addr_q[b].scm.region;
    assign scm_addr_o[b]   = addr_q[b].scm.addr;
    assign pipe_scm_o[b]   = addr_q[b].scm.region;
  end

  assign sram_wen_o   = wen_q;
  assign sram_wdata_o = wdata_q;
  assign sram_be_o    = be_q;
  assign scm_wen_o    = wen_q;
  assign scm_wdata_o  = wdata_q;
  assign scm_be_o     = be_q;

  assign pipe_valid_o = req_q;
  assign pipe_id_o    = id_q;

endmodule

`default_nettype wire

// ==== hdl/tcdm_req_router.sv ====
// address decode, request mux and response scatter
// fully combinational, the arbiter picks the master per bank
// byte offset and address bits above the map are dropped here
`include "tcdm_cfg.svh"
`default_nettype none

module tcdm_req_router
  import tcdm_addr_pkg::*, tcdm_bus_pkg::*;
(
  input  logic [`TCDM_N_MASTER-1:0]                   req_i,
  input  logic [`TCDM_N_MASTER-1:0][`TCDM_ADDR_W-1:0] addr_i,
  input  logic [`TCDM_N_MASTER-1:0]                   wen_i,
  input  data_t [`TCDM_N_MASTER-1:0]                  wdata_i,
  input  be_t   [`TCDM_N_MASTER-1:0]                  be_i,
  output logic [`TCDM_N_MASTER-1:0][`TCDM_N_BANK-1:0] bank_hit_o,
  input  logic [`TCDM_N_BANK-1:0]                     gnt_valid_i,
  input  master_idx_t [`TCDM_N_BANK-1:0]              gnt_idx_i,
  tcdm_bank_req_if.router                             bank_req,
  tcdm_bank_resp_if.router                            bank_resp,
  output logic [`TCDM_N_MASTER-1:0]                   r_valid_o,
  output data_t [`TCDM_N_MASTER-1:0]                  r_rdata_o
);

  bank_idx_t [`TCDM_N_MASTER-1:0] bank_sel;
  mem_addr_u [`TCDM_N_MASTER-1:0] mem_addr;

  // bank field and bank-local word of every master
  always_comb
  begin
    for (int m = 0; m < `TCDM_N_MASTER; m++)
    begin
      bank_sel[m]      = bank_idx_t'(addr_i[m] >> TCDM_BANK_LSB);
      mem_addr[m].word = addr_i[m][TCDM_MEM_LSB +: `TCDM_MEM_AW];
      for (int b = 0; b < `TCDM_N_BANK; b++)
        bank_hit_o[m][b] = req_i[m] && (bank_sel[m] == bank_idx_t'(b));
    end
  end

  //////////////////////////////////////////////////
  // granted master onto each bank
  //////////////////////////////////////////////////
  for (genvar b = 0; b < `TCDM_N_BANK; b++)
  begin : g_bank_mux
    assign bank_req.req[b]   = gnt_valid_i[b];
    assign bank_req.addr[b]  = mem_addr[gnt_idx_i[b]];
    assign bank_req.wen[b]   = wen_i[gnt_idx_i[b]];
    assign bank_req.wdata[b] = wdata_i[gnt_idx_i[b]];
    assign bank_req.be[b]    = be_i[gnt_idx_i[b]];
    assign bank_req.id[b]    = gnt_idx_i[b];
  end

  // response back to the issuing master
  // at most one bank answers a given master per cycle
  always_comb
  begin
    r_valid_o = '0;
    r_rdata_o = '0;
    for (int b = 0; b < `TCDM_N_BANK; b++)
    begin
      if (bank_resp.rvalid[b])
      begin
        r_valid_o[bank_resp.id[b]] = 1'b1;
        r_rdata_o[bank_resp.id[b]] = bank_resp.rdata[b];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tcdm_arbiter.sv ====
// round-robin grant per bank
// grant is combinational on bank_hit, only the pointers are flopped
// a master hits at most one bank per cycle, so gnt_o is a plain OR
`include "tcdm_cfg.svh"
`default_nettype none

module tcdm_arbiter
  import tcdm_bus_pkg::*;
(
  input  logic                                        clk,
  input  logic                                        arst_n_i,
  // active requests, [master][bank]
  input  logic [`TCDM_N_MASTER-1:0][`TCDM_N_BANK-1:0] bank_hit_i,
  output logic [`TCDM_N_MASTER-1:0]                   gnt_o,
  output logic [`TCDM_N_BANK-1:0]                     gnt_valid_o,
  output master_idx_t [`TCDM_N_BANK-1:0]              gnt_idx_o
);

  // next master to favour, per bank
  master_idx_t [`TCDM_N_BANK-1:0] ptr_q;
  logic        [`TCDM_N_BANK-1:0] gnt_valid;
  master_idx_t [`TCDM_N_BANK-1:0] gnt_idx;

  //////////////////////////////////////////////////
  // priority search starting at the pointer
  //////////////////////////////////////////////////
  always_comb
  begin
    master_idx_t cand;
    cand = '0;
    for (int b = 0; b < `TCDM_N_BANK; b++)
    begin
      gnt_valid[b] = 1'b0;
      gnt_idx[b]   = '0;
      // walk downwards so the candidate closest to the pointer wins
      for (int k = `TCDM_N_MASTER - 1; k >= 0; k--)
      begin
        cand = ptr_q[b] + master_idx_t'(k);
        if (bank_hit_i[cand][b])
        begin
          gnt_valid[b] = 1'b1;
          gnt_idx[b]   = cand;
        end
      end
    end
  end

  // fold bank grants back onto the masters
  always_comb
  begin
    gnt_o = '0;
    for (int b = 0; b < `TCDM_N_BANK; b++)
    begin
      if (gnt_valid[b])
        gnt_o[gnt_idx[b]] = 1'b1;
    end
  end

  assign gnt_valid_o = gnt_valid;
  assign gnt_idx_o   = gnt_idx;

  // pointer moves one past the winner at the grant edge
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      ptr_q <= '0;
    else
    begin
      for (int b = 0; b < `TCDM_N_BANK; b++)
      begin
        if (gnt_valid[b])
          ptr_q[b] <= gnt_idx[b] + master_idx_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tcdm_bank_if.sv ====
// bank-side request and response bundles, one entry per bank
// wen follows the TCDM convention, 1 is a load and 0 a store
// responses have no ready, masters always take them
`include "tcdm_cfg.svh"
`default_nettype none

//////////////////////////////////////////////////
// request, router to bank pipe
//////////////////////////////////////////////////
interface tcdm_bank_req_if
  import tcdm_addr_pkg::*, tcdm_bus_pkg::*;
();

  logic        [`TCDM_N_BANK-1:0] req;
  // bank-local word address, region bit on top
  mem_addr_u   [`TCDM_N_BANK-1:0] addr;
  logic        [`TCDM_N_BANK-1:0] wen;
  data_t       [`TCDM_N_BANK-1:0] wdata;
  be_t         [`TCDM_N_BANK-1:0] be;
  // granted master, travels along to steer the response
  master_idx_t [`TCDM_N_BANK-1:0] id;

  modport router (output req, addr, wen, wdata, be, id);
  modport pipe   (input  req, addr, wen, wdata, be, id);

endinterface

//////////////////////////////////////////////////
// response, resp router back to the master side
//////////////////////////////////////////////////
interface tcdm_bank_resp_if
  import tcdm_bus_pkg::*;
();

  logic        [`TCDM_N_BANK-1:0] rvalid;
  data_t       [`TCDM_N_BANK-1:0] rdata;
  master_idx_t [`TCDM_N_BANK-1:0] id;

  modport resp   (output rvalid, rdata, id);
  modport router (input  rvalid, rdata, id);

endinterface

`default_nettype wire

// ==== hdl/tcdm_bus_pkg.sv ====
// bus types shared by the crossbar blocks
// index widths follow the master and bank counts of the config header
`include "tcdm_cfg.svh"
`default_nettype none

package tcdm_bus_pkg;

  // which master issued a request
  typedef logic [$clog2(`TCDM_N_MASTER)-1:0] master_idx_t;

  // which bank a request goes to
  typedef logic [$clog2(`TCDM_N_BANK)-1:0] bank_idx_t;

  // payload
  typedef logic [`TCDM_DATA_W-1:0] data_t;
  typedef logic [`TCDM_BE_W-1:0]   be_t;

endpackage

`default_nettype wire

// ==== hdl/tcdm_addr_pkg.sv ====
// address map of the crossbar
// byte offset 1:0, bank 3:2, bank-local word address 14:4
// bits above the word address are ignored, no range error is raised
`include "tcdm_cfg.svh"
`default_nettype none

package tcdm_addr_pkg;

  // field positions inside the master byte address
  localparam int unsigned TCDM_BANK_LSB = 2;
  localparam int unsigned TCDM_MEM_LSB  = 4;

  // region bit clear, SRAM word address below it
  typedef struct packed {
    logic                     region;
    logic [`TCDM_SRAM_AW-1:0] addr;
  } sram_view_t;

  // region bit set, gap bits unused, SCM word address at the bottom
  typedef struct packed {
    logic                                     region;
    logic [`TCDM_MEM_AW-`TCDM_SCM_AW-2:0]     unused;
    logic [`TCDM_SCM_AW-1:0]                  addr;
  } scm_view_t;

  // one bank-local word, decoded as SRAM or SCM by the region bit
  typedef union packed {
    logic [`TCDM_MEM_AW-1:0] word;
    sram_view_t              sram;
    scm_view_t               scm;
  } mem_addr_u;

endpackage

`default_nettype wire

// ==== hdl/tcdm_cfg.svh ====
// configuration of the TCDM crossbar
// N_BANK must stay a power of two, the bank field is taken straight
// from the address bits above the byte offset
// MEM_AW includes the region bit as its top bit
// SRAM_AW + 1 and SCM_AW + 1 must both fit in MEM_AW
`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

// bus geometry
`define TCDM_N_MASTER 4
`define TCDM_N_BANK   4
`define TCDM_DATA_W   32
`define TCDM_ADDR_W   32
`define TCDM_BE_W     (`TCDM_DATA_W/8)

// bank-local word address split
`define TCDM_MEM_AW   11
`define TCDM_SRAM_AW  10
`define TCDM_SCM_AW   8

`endif
